// File: rtl/conv_store_controller.sv
`timescale 1ns/10ps
`default_nettype none

`include "conv_store_defines.svh"

module conv_store_controller (
    input  wire logic                      clk,
    input  wire logic                      reset,
    input  wire conv_store_pkg::tile_cfg_t cfg,
    input  wire logic                      tile_start,
    output logic [`FIFO_NUM-1:0]           fifo_rd,
    output logic [3:0]                     fifo_sel,
    input  wire conv_store_pkg::row_t      fifo_data,
    output conv_store_pkg::out_beat_t      beat,
    output logic                           tile_done
);

    import conv_store_pkg::*;

    localparam int ROW_BITS = $clog2(`SA_ROW_NUM);
    localparam int COL_BITS = $clog2(`SA_COL_NUM);

    logic              active;
    logic [`IDX_W-1:0] channel_counter;
    logic [`IDX_W-1:0] of_counter;
    logic [`IDX_W-1:0] oy_counter;
    logic [`IDX_W-1:0] channel_num;
    logic [3:0]        log_channel_num;
    logic [`IDX_W-1:0] of_m1;
    logic [`IDX_W-1:0] oy_m1;
    logic [`IDX_W-1:0] of_block;
    logic              pof_reached;
    logic              channel_end;
    logic              of_end;
    logic              oy_end;
    logic              rd_en;
    logic [3:0]        rd_idx;

    // registered beat fields
    logic                valid_q;
    logic [`IDX_W-1:0]   y_idx_q;
    logic [`IDX_W-1:0]   x_idx_q;
    logic [`IDX_W-1:0]   f_idx_q;
    logic                upper_q;
    logic [ROW_BITS-1:0] fifo_row_no;
    logic [COL_BITS-1:0] fifo_column_no;

    // 16 channels per entry in mode 0 and 32 in mode 1
    assign channel_num     = cfg.mode ? `IDX_W'(32) : `IDX_W'(16);
    assign log_channel_num = cfg.mode ? 4'd5 : 4'd4;

    assign of_m1    = of_counter - 1'b1;
    assign oy_m1    = oy_counter - 1'b1;
    assign of_block = of_m1 >> log_channel_num;

    ////////////////////////////////////////
    // loop control
    ////////////////////////////////////////

    assign pof_reached = (of_m1 + channel_counter == cfg.pof);
    assign channel_end = active && (pof_reached || (channel_counter == channel_num));
    assign of_end      = channel_end && pof_reached;
    assign oy_end      = of_end && (oy_counter == cfg.poy);

    always_ff @(posedge clk) begin
        if (reset) begin
            active <= 1'b0;
        end else if (tile_start) begin
            active <= 1'b1;
        end else if (oy_end) begin
            active <= 1'b0;
        end
    end

    // 1-based channel, of and oy counters
    always_ff @(posedge clk) begin
        if (reset) begin
            channel_counter <= `IDX_W'(1);
            of_counter      <= `IDX_W'(1);
            oy_counter      <= `IDX_W'(1);
        end else if (active) begin
            channel_counter <= channel_end ? `IDX_W'(1) : channel_counter + 1'b1;
            if (channel_end) begin
                of_counter <= of_end ? `IDX_W'(1) : of_counter + channel_num;
            end
            if (of_end) begin
                oy_counter <= oy_end ? `IDX_W'(1) : oy_counter + 1'b1;
            end
        end
    end

    ////////////////////////////////////////
    // fifo read strobes
    ////////////////////////////////////////

    // mode 1 reads once per channel pair
    assign rd_en  = active && (!cfg.mode || channel_counter[0]);
    assign rd_idx = {oy_m1[COL_BITS-1:0], of_block[ROW_BITS-1:0]};

    always_comb begin
        for (int i = 0; i < `FIFO_NUM; i++) begin
            fifo_rd[i] = rd_en && (rd_idx == 4'(i));
        end
    end

    ////////////////////////////////////////
    // output beat
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_q   <= 1'b0;
            tile_done <= 1'b0;
        end else begin
            valid_q   <= active;
            tile_done <= oy_end;
        end
    end

    // indices and fifo index of the current step
    always_ff @(posedge clk) begin
        if (active) begin
            y_idx_q        <= cfg.oy_start - 1'b1 + oy_counter;
            x_idx_q        <= cfg.ox_start;
            f_idx_q        <= cfg.of_start - 1'b1 + of_m1 + channel_counter;
            upper_q        <= cfg.mode && channel_counter[0];
            fifo_row_no    <= of_block[ROW_BITS-1:0];
            fifo_column_no <= oy_m1[COL_BITS-1:0];
        end
    end

    // index of the fifo whose rd_data is on fifo_data
    assign fifo_sel = {fifo_column_no, fifo_row_no};

    assign beat.valid = valid_q;
    assign beat.y_idx = y_idx_q;
    assign beat.x_idx = x_idx_q;
    assign beat.f_idx = f_idx_q;
    // upper half goes out first in mode 1
    assign beat.data  = !valid_q ? '0 :
                        upper_q  ? fifo_data[`ROW_W-1:`OUT_W] :
                                   fifo_data[`OUT_W-1:0];

    a_start_idle: assert property (@(posedge clk) disable iff (reset) tile_start |-> !active)
        else $error("conv_store_controller: tile_start while a tile is active");

endmodule

`default_nettype wire

// File: rtl/conv_store_defines.svh
`ifndef CONV_STORE_DEFINES_SVH
`define CONV_STORE_DEFINES_SVH

// systolic core geometry
`define SA_ROW_NUM 4
`define SA_COL_NUM 3
`define FIFO_NUM   (`SA_ROW_NUM * `SA_COL_NUM)

// PE columns in one array
`define COLUMN_NUM 4

// quantized data widths
`define PIXEL_W 8
`define ROW_W   (`PIXEL_W * 2 * 2 * `COLUMN_NUM)
`define OUT_W   (`PIXEL_W * 2 * `COLUMN_NUM)

// entries per row fifo
`define FIFO_DEPTH 8

// pixel and channel index fields
`define IDX_W 16

`endif

// File: rtl/conv_store_pkg.sv
`default_nettype none

`include "conv_store_defines.svh"

package conv_store_pkg;

    // one quantized row as stored in a fifo entry
    typedef logic [`ROW_W-1:0] row_t;

    // core result write to the fifo that sel picks
    typedef struct packed {
        logic             valid;
        logic [3:0]       sel;
        row_t             data;
    } wr_req_t;

    ////////////////////////////////////////
    // tile configuration
    ////////////////////////////////////////

    // held stable from tile_start until tile_done
    typedef struct packed {
        logic             mode;
        logic [`IDX_W-1:0] ox_start;
        logic [`IDX_W-1:0] oy_start;
        logic [`IDX_W-1:0] of_start;
        logic [`IDX_W-1:0] pox;
        logic [`IDX_W-1:0] poy;
        logic [`IDX_W-1:0] pof;
    } tile_cfg_t;

    // one output beat with its pixel indices
    typedef struct packed {
        logic              valid;
        logic [`IDX_W-1:0] y_idx;
        logic [`IDX_W-1:0] x_idx;
        logic [`IDX_W-1:0] f_idx;
        logic [`OUT_W-1:0] data;
    } out_beat_t;

endpackage

`default_nettype wire

// File: rtl/conv_store_top.sv
`timescale 1ns/10ps
`default_nettype none

`include "conv_store_defines.svh"

module conv_store_top (
    input  wire logic                      clk,
    input  wire logic                      reset,
    input  wire conv_store_pkg::wr_req_t   wr_req,
    input  wire conv_store_pkg::tile_cfg_t cfg,
    input  wire logic                      tile_start,
    output conv_store_pkg::out_beat_t      beat,
    output logic                           tile_done,
    output logic                           fifo_overflow
);

    import conv_store_pkg::*;

    logic [`FIFO_NUM-1:0] fifo_wr;
    logic [`FIFO_NUM-1:0] fifo_rd;
    logic [`FIFO_NUM-1:0] fifo_full;
    row_t                 wr_data;
    row_t                 rd_data [`FIFO_NUM];
    logic [3:0]           fifo_sel;
    row_t                 fifo_data;

    // core rows into the fifos
    sa_result_collector i_collector (
        .clk           (clk),
        .reset         (reset),
        .wr_req        (wr_req),
        .fifo_full     (fifo_full),
        .fifo_wr       (fifo_wr),
        .wr_data       (wr_data),
        .fifo_overflow (fifo_overflow)
    );

    ////////////////////////////////////////
    // one fifo per array
    ////////////////////////////////////////

    for (genvar i = 0; i < `FIFO_NUM; i++) begin : g_fifo
        row_fifo i_row_fifo (
            .clk     (clk),
            .reset   (reset),
            .wr      (fifo_wr[i]),
            .wr_data (wr_data),
            .rd      (fifo_rd[i]),
            .rd_data (rd_data[i]),
            .full    (fifo_full[i]),
            .empty   ()
        );
    end

    // read data of the fifo read in the previous cycle
    assign fifo_data = rd_data[fifo_sel];

    conv_store_controller i_controller (
        .clk        (clk),
        .reset      (reset),
        .cfg        (cfg),
        .tile_start (tile_start),
        .fifo_rd    (fifo_rd),
        .fifo_sel   (fifo_sel),
        .fifo_data  (fifo_data),
        .beat       (beat),
        .tile_done  (tile_done)
    );

endmodule

`default_nettype wire

// File: rtl/row_fifo.sv
`timescale 1ns/10ps
`default_nettype none

`include "conv_store_defines.svh"

module row_fifo (
    input  wire logic                 clk,
    input  wire logic                 reset,
    input  wire logic                 wr,
    input  wire conv_store_pkg::row_t wr_data,
    input  wire logic                 rd,
    output conv_store_pkg::row_t      rd_data,
    output logic                      full,
    output logic                      empty
);

    import conv_store_pkg::*;

    localparam int PTR_W = $clog2(`FIFO_DEPTH);

    row_t             mem [`FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    // one bit wider than the pointers to tell full from empty
    logic [PTR_W:0]   count;

    assign full  = (count == `FIFO_DEPTH);
    assign empty = (count == '0);

    // storage
    always_ff @(posedge clk) begin
        if (wr) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    // registered read port with data valid the cycle after rd
    always_ff @(posedge clk) begin
        if (rd) begin
            rd_data <= mem[rd_ptr];
        end
    end

    // pointers and fill level
    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({wr, rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // reads come from the controller and writes from the collector
    a_no_read_empty: assert property (@(posedge clk) disable iff (reset) rd |-> !empty)
        else $error("row_fifo: read while empty");
    a_no_write_full: assert property (@(posedge clk) disable iff (reset) wr |-> !full)
        else $error("row_fifo: write while full");

endmodule

`default_nettype wire

// File: rtl/sa_result_collector.sv
`timescale 1ns/10ps
`default_nettype none

`include "conv_store_defines.svh"

module sa_result_collector (
    input  wire logic                    clk,
    input  wire logic                    reset,
    input  wire conv_store_pkg::wr_req_t wr_req,
    input  wire logic [`FIFO_NUM-1:0]    fifo_full,
    output logic [`FIFO_NUM-1:0]         fifo_wr,
    output conv_store_pkg::row_t         wr_data,
    output logic                         fifo_overflow
);

    import conv_store_pkg::*;

    wr_req_t              req_q;
    logic [`FIFO_NUM-1:0] sel_onehot;
    logic                 hit_full;

    ////////////////////////////////////////
    // input register
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        req_q <= wr_req;
        if (reset) begin
            req_q.valid <= 1'b0;
        end
    end

    // sel decode
    always_comb begin
        sel_onehot = '0;
        if (req_q.valid && (req_q.sel < `FIFO_NUM)) begin
            sel_onehot[req_q.sel] = 1'b1;
        end
    end

    // drop the write if the target is already full
    assign fifo_wr  = sel_onehot & ~fifo_full;
    assign wr_data  = req_q.data;
    assign hit_full = |(sel_onehot & fifo_full);

    ////////////////////////////////////////
    // overflow flag
    ////////////////////////////////////////

    // sticky until reset
    always_ff @(posedge clk) begin
        if (reset) begin
            fifo_overflow <= 1'b0;
        end else if (hit_full) begin
            fifo_overflow <= 1'b1;
        end
    end

    a_sel_range: assert property (@(posedge clk) disable iff (reset)
        wr_req.valid |-> (wr_req.sel < `FIFO_NUM))
        else $error("sa_result_collector: sel %0d out of range", wr_req.sel);

endmodule

`default_nettype wire

// File: run_sim.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_conv_store -f tb.f -o sim_conv_store

out=$(./obj_dir/sim_conv_store)
echo "$out"

if echo "$out" | grep -qx "TESTS PASSED"; then
    exit 0
else
    exit 1
fi

// File: tb.f
+incdir+rtl
rtl/conv_store_pkg.sv
rtl/row_fifo.sv
rtl/sa_result_collector.sv
rtl/conv_store_controller.sv
rtl/conv_store_top.sv
testbench/tb_conv_store.sv

// File: testbench/conv_store_golden.txt
# T name mode ox_start oy_start of_start pox poy pof, then the W and E lines of that test
# W sel rows first_entry ; E y x f beats sel first_entry ; entries are a fill of sel and entry
T m0_single 0 7 3 9 1 1 16
W 0 16 0
E 3 7 9 16 0 0
T m1_pair 1 2 10 1 1 1 32
W 0 16 32
E 10 2 1 32 0 32
T m1_two_rows 1 0 40 65 1 2 32
W 0 16 100
W 4 16 16
E 40 0 65 32 0 100
E 41 0 65 32 4 16
T m0_multi 0 4 20 100 1 3 40
W 0 16 48
W 1 16 0
W 2 8 0
W 4 16 0
W 5 16 0
W 6 8 0
W 8 16 0
W 9 16 0
W 10 8 0
E 20 4 100 16 0 48
E 20 4 116 16 1 0
E 20 4 132 8 2 0
E 21 4 100 16 4 0
E 21 4 116 16 5 0
E 21 4 132 8 6 0
E 22 4 100 16 8 0
E 22 4 116 16 9 0
E 22 4 132 8 10 0
T overflow 0 0 0 0 0 0 0
W 11 9 0

// File: testbench/tb_conv_store.sv
`timescale 1ns/10ps
`default_nettype none

`include "conv_store_defines.svh"

module tb_conv_store;

    import conv_store_pkg::*;

    localparam int TIMEOUT = 200;
    localparam int PRELOAD = 6;

    logic      clk;
    logic      reset;
    wr_req_t   wr_req;
    tile_cfg_t cfg;
    logic      tile_start;
    out_beat_t beat;
    logic      tile_done;
    logic      fifo_overflow;

    // rows to write and beats to expect for the pending test
    int                wr_sel_q[$];
    int                wr_k_q[$];
    int                exp_y_q[$];
    int                exp_x_q[$];
    int                exp_f_q[$];
    logic [`OUT_W-1:0] exp_data_q[$];
    int                read_count [`FIFO_NUM];
    int                fifo_fill [`FIFO_NUM];
    tile_cfg_t         pending_cfg;
    string             test_name;
    logic              ovf_expected;
    int                issued;
    int                reads_seen;
    int                test_errors;
    int                tests;
    int                failed;

    conv_store_top i_dut (
        .clk           (clk),
        .reset         (reset),
        .wr_req        (wr_req),
        .cfg           (cfg),
        .tile_start    (tile_start),
        .beat          (beat),
        .tile_done     (tile_done),
        .fifo_overflow (fifo_overflow)
    );

    always #2 clk = ~clk;

    // beat data for fifo sel and entry k in half h
    function automatic logic [`OUT_W-1:0] half_word(int sel, int k, int h);
        logic [15:0] w;
        w = {4'(h), 4'(sel), 8'(k)};
        return {4{w}};
    endfunction

    function automatic row_t row_fill(int sel, int k);
        return {half_word(sel, k, 1), half_word(sel, k, 0)};
    endfunction

    task automatic abort_run(string why);
        $display("%s: %s", test_name, why);
        $display("TESTS FAILED");
        $finish;
    endtask

    task automatic check_value(string what, logic [63:0] exp, logic [63:0] act);
        assert (exp == act) else begin
            $display("** Error %s %s: expected %0h, actual %0h", test_name, what, exp, act);
            test_errors++;
        end
    endtask

    task automatic finish_test();
        tests++;
        if (test_errors != 0) begin
            failed++;
        end
        $display("test %-12s %s", test_name, (test_errors == 0) ? "ok" : "failing");
    endtask

    // outputs stay quiet while no tile runs
    task automatic check_idle(string name, int cycles);
        test_name   = name;
        test_errors = 0;
        repeat (cycles) begin
            @(negedge clk);
            check_value("beat.valid", 0, beat.valid);
            check_value("tile_done", 0, tile_done);
            check_value("fifo_overflow", ovf_expected, fifo_overflow);
        end
        finish_test();
    endtask

    // one row per cycle paced against the reads seen so far
    task automatic stream_rows(logic paced);
        int sel;
        int k;
        int stalls;
        stalls = 0;
        while (wr_sel_q.size() > 0) begin
            @(posedge clk);
            if (paced && (issued - reads_seen >= 7)) begin
                wr_req.valid <= 1'b0;
                stalls++;
                if (stalls > TIMEOUT) begin
                    abort_run("row writes stalled, no beats came out");
                end
            end else begin
                sel = wr_sel_q.pop_front();
                k   = wr_k_q.pop_front();
                wr_req.valid <= 1'b1;
                wr_req.sel   <= 4'(sel);
                wr_req.data  <= row_fill(sel, k);
                issued++;
                stalls = 0;
            end
        end
        @(posedge clk);
        wr_req.valid <= 1'b0;
    endtask

    task automatic collect_beats(int preload);
        int cycles;
        int n;
        cycles = 0;
        while (issued < preload) begin
            @(negedge clk);
            cycles++;
            if (cycles > TIMEOUT) begin
                abort_run("rows were not written before the tile start");
            end
        end
        @(posedge clk);
        tile_start <= 1'b1;
        @(posedge clk);
        tile_start <= 1'b0;
        n = exp_f_q.size();
        for (int i = 0; i < n; i++) begin
            @(negedge clk);
            cycles = 1;
            while (!beat.valid) begin
                check_value("tile_done", 0, tile_done);
                if (cycles >= TIMEOUT) begin
                    abort_run("timed out waiting for beat.valid");
                end
                @(negedge clk);
                cycles++;
            end
            // beats of one tile come back to back
            if (i > 0) begin
                check_value("beat gap", 1, cycles);
            end
            check_value("y_idx", exp_y_q.pop_front(), beat.y_idx);
            check_value("x_idx", exp_x_q.pop_front(), beat.x_idx);
            check_value("f_idx", exp_f_q.pop_front(), beat.f_idx);
            check_value("data", exp_data_q.pop_front(), beat.data);
            check_value("tile_done", (i == n - 1), tile_done);
            if (!pending_cfg.mode || (i % 2 == 0)) begin
                reads_seen++;
            end
        end
        @(negedge clk);
        check_value("beat after done", 0, beat.valid);
        check_value("tile_done", 0, tile_done);
    endtask

    task automatic run_test();
        int   total;
        logic paced;
        repeat ($urandom % 4) @(posedge clk);
        @(posedge clk);
        cfg <= pending_cfg;
        test_errors = 0;
        issued      = 0;
        reads_seen  = 0;
        total       = wr_sel_q.size();
        paced       = (pending_cfg.poy != 0);
        // fifo fill after this test with any excess dropped
        foreach (wr_sel_q[i]) begin
            fifo_fill[wr_sel_q[i]]++;
        end
        for (int s = 0; s < `FIFO_NUM; s++) begin
            fifo_fill[s]  = fifo_fill[s] - read_count[s];
            read_count[s] = 0;
            if (fifo_fill[s] > `FIFO_DEPTH) begin
                ovf_expected = 1'b1;
                fifo_fill[s] = `FIFO_DEPTH;
            end
        end
        fork
            stream_rows(paced);
            if (paced) begin
                collect_beats((total < PRELOAD) ? total : PRELOAD);
            end
        join
        // collector latency before the flag settles
        repeat (3) @(negedge clk);
        check_value("fifo_overflow", ovf_expected, fifo_overflow);
        finish_test();
    endtask

    initial begin
        int    fd;
        int    code;
        string kind;
        string line;
        int    mode;
        int    ox;
        int    oy;
        int    of;
        int    pox;
        int    poy;
        int    pof;
        int    sel;
        int    n;
        int    k;
        int    y;
        int    x;
        int    f;
        logic  have_test;

        void'($urandom(32'h5f58a3f7));
        clk          = 1'b0;
        reset        = 1'b1;
        wr_req       = '0;
        cfg          = '0;
        tile_start   = 1'b0;
        pending_cfg  = '0;
        ovf_expected = 1'b0;
        tests        = 0;
        failed       = 0;
        have_test    = 1'b0;
        test_name    = "setup";
        for (int s = 0; s < `FIFO_NUM; s++) begin
            read_count[s] = 0;
            fifo_fill[s]  = 0;
        end
        repeat (3) @(posedge clk);
        reset <= 1'b0;
        check_idle("reset_idle", 5);

        fd = $fopen("testbench/conv_store_golden.txt", "r");
        if (fd == 0) begin
            abort_run("cannot open the golden file");
        end
        while ($fscanf(fd, "%s", kind) == 1) begin
            if (kind == "#") begin
                code = $fgets(line, fd);
            end else if (kind == "T") begin
                if (have_test) begin
                    run_test();
                end
                code = $fscanf(fd, "%s %d %d %d %d %d %d %d",
                               line, mode, ox, oy, of, pox, poy, pof);
                test_name            = line;
                pending_cfg.mode     = mode[0];
                pending_cfg.ox_start = 16'(ox);
                pending_cfg.oy_start = 16'(oy);
                pending_cfg.of_start = 16'(of);
                pending_cfg.pox      = 16'(pox);
                pending_cfg.poy      = 16'(poy);
                pending_cfg.pof      = 16'(pof);
                have_test            = 1'b1;
            end else if (kind == "W") begin
                code = $fscanf(fd, "%d %d %d", sel, n, k);
                for (int i = 0; i < n; i++) begin
                    wr_sel_q.push_back(sel);
                    wr_k_q.push_back(k + i);
                end
            end else if (kind == "E") begin
                code = $fscanf(fd, "%d %d %d %d %d %d", y, x, f, n, sel, k);
                // mode 1 sends the upper half of each entry first
                for (int i = 0; i < n; i++) begin
                    exp_y_q.push_back(y);
                    exp_x_q.push_back(x);
                    exp_f_q.push_back(f + i);
                    if (pending_cfg.mode) begin
                        exp_data_q.push_back(half_word(sel, k + i / 2, (i % 2 == 0) ? 1 : 0));
                    end else begin
                        exp_data_q.push_back(half_word(sel, k + i, 0));
                    end
                end
                read_count[sel] += pending_cfg.mode ? n / 2 : n;
            end else begin
                abort_run("unknown line kind in the golden file");
            end
        end
        if (have_test) begin
            run_test();
        end
        $fclose(fd);
        check_idle("final_idle", 5);

        $display("%0d tests, %0d passed, %0d failing", tests, tests - failed, failed);
        if (failed == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
